/* bench/cpu_tb.sv */
`timescale 1ns/10ps

module cpu_tb;

	localparam int CLK_PERIOD     = 10;
	localparam int RESET_CYCLES   = 5;
	localparam int NUM_INSTR      = 60;
	localparam int PROG_LEN       = NUM_INSTR + 9;	// random part, 8 stores, final jump
	localparam int STORE_BASE     = 56;	// final register dump area
	localparam int IMEM_DEPTH     = 256;
	localparam int DMEM_DEPTH     = 64;
	localparam int MAX_STEPS      = 1000;
	localparam int TIMEOUT_CYCLES = PROG_LEN * 12 + 200;

	logic           clk;
	logic           rst;
	logic           en_i;
	cpu_pkg::word_t imem_addr;
	cpu_pkg::word_t imem_data;
	logic           dmem_req;
	logic           dmem_we;
	cpu_pkg::word_t dmem_addr;
	cpu_pkg::word_t dmem_wdata;
	cpu_pkg::word_t dmem_rdata;
	logic           dmem_wait;

	int               seed = 32'h48265e87;
	cpu_pkg::word_t   imem [IMEM_DEPTH];
	cpu_pkg::word_t   dmem [DMEM_DEPTH];	// written by the dut's stores
	cpu_pkg::word_t   model_mem [DMEM_DEPTH];
	cpu_pkg::word_t   model_regs [8];
	cpu_pkg::opcode_t prog_op [PROG_LEN];
	logic             prog_imm [PROG_LEN];
	cpu_pkg::word_t   prog_addr [PROG_LEN];
	cpu_pkg::word_t   fetch_trace [$];	// instruction addresses in execution order
	cpu_pkg::word_t   acc_addr [$];
	cpu_pkg::word_t   acc_data [$];
	logic             acc_store [$];
	cpu_pkg::word_t   got_stores [$];
	cpu_pkg::word_t   halt_addr;
	int               fetch_idx = 0;
	int               acc_idx = 0;
	int               wait_left = 0;

	cpu_top dut_i (
		.clk          (clk),
		.rst          (rst),
		.en_i         (en_i),
		.imem_addr_o  (imem_addr),
		.imem_data_i  (imem_data),
		.dmem_req_o   (dmem_req),
		.dmem_we_o    (dmem_we),
		.dmem_addr_o  (dmem_addr),
		.dmem_wdata_o (dmem_wdata),
		.dmem_rdata_i (dmem_rdata),
		.dmem_wait_i  (dmem_wait)
	);

	assign imem_data = imem[imem_addr[7:0]];	// combinational instruction port

	function automatic logic [31:0] draw_random();
		return $random(seed);
	endfunction

	function automatic cpu_pkg::word_t data_fill(input int a);
		return cpu_pkg::word_t'(a * 'h0b3d) ^ 16'h6c5a;
	endfunction

	task automatic abort_run();
		$display("Test failures found");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_word(input string name, input cpu_pkg::word_t exp,
		input cpu_pkg::word_t act);
		assert (act === exp) else begin
			$display("Error: %s expected %h actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic build_program();
		logic [31:0]    r;
		logic [31:0]    r2;
		cpu_pkg::word_t pc;
		cpu_pkg::word_t immw;
		logic [2:0]     rd;
		logic [2:0]     rs;
		logic [4:0]     low;
		int             j;
		for (int a = 0; a < IMEM_DEPTH; a++) begin
			imem[a] = {8'hf0, 8'(a)};	// unused opcode does nothing if reached
		end
		pc = '0;
		for (int i = 0; i < PROG_LEN; i++) begin
			r = draw_random();
			if (i < NUM_INSTR) begin
				prog_op[i]  = cpu_pkg::opcode_t'(4'(r % 12));
				prog_imm[i] = r[4];
				if (prog_op[i] == cpu_pkg::BZ || prog_op[i] == cpu_pkg::JMP) begin
					prog_imm[i] = 1'b1;	// targets always come from the immediate
				end
			end else begin
				prog_op[i]  = (i < NUM_INSTR + 8) ? cpu_pkg::ST : cpu_pkg::JMP;
				prog_imm[i] = 1'b1;
			end
			prog_addr[i] = pc;
			pc = pc + (prog_imm[i] ? 16'd2 : 16'd1);
		end
		for (int i = 0; i < PROG_LEN; i++) begin
			r   = draw_random();
			rd  = (i < NUM_INSTR) ? r[2:0] : 3'(i - NUM_INSTR);
			rs  = (i < NUM_INSTR) ? r[5:3] : 3'd0;
			low = (i < NUM_INSTR) ? r[10:6] : 5'd0;
			imem[prog_addr[i][7:0]] = {prog_op[i], rd, rs, prog_imm[i], low};
			if (prog_imm[i]) begin
				r2 = draw_random();
				if (i >= NUM_INSTR + 8) begin
					immw = prog_addr[i];	// final jump to itself
				end else if (i >= NUM_INSTR) begin
					immw = 16'(STORE_BASE + i - NUM_INSTR);
				end else if (prog_op[i] == cpu_pkg::LD || prog_op[i] == cpu_pkg::ST) begin
					immw = 16'(r2[5:0]);
				end else if (prog_op[i] == cpu_pkg::BZ || prog_op[i] == cpu_pkg::JMP) begin
					j    = i + 1 + int'(r2 % (NUM_INSTR - i));	// forward only
					immw = prog_addr[j];
				end else begin
					immw = r2[15:0];
				end
				imem[prog_addr[i][7:0] + 8'd1] = immw;
			end
		end
	endtask

	task automatic run_model();
		cpu_pkg::word_t   pc;
		cpu_pkg::word_t   cur;
		cpu_pkg::word_t   w;
		cpu_pkg::word_t   a;
		cpu_pkg::word_t   b;
		cpu_pkg::opcode_t op;
		logic [2:0]       rd;
		logic             halted;
		int               steps;
		for (int r = 0; r < 8; r++) begin
			model_regs[r] = '0;
		end
		for (int m = 0; m < DMEM_DEPTH; m++) begin
			model_mem[m] = data_fill(m);
			dmem[m]      = data_fill(m);
		end
		pc     = '0;
		cur    = '0;
		halted = 1'b0;
		steps  = 0;
		while (!halted && steps < MAX_STEPS) begin
			cur = pc;
			fetch_trace.push_back(cur);
			w  = imem[cur[7:0]];
			op = cpu_pkg::opcode_t'(w[15:12]);
			rd = w[11:9];
			pc = cur + 16'd1;
			if (w[5]) begin
				b  = imem[pc[7:0]];
				pc = pc + 16'd1;
			end else begin
				b = model_regs[w[8:6]];
			end
			a = model_regs[rd];
			case (op)
				cpu_pkg::ADD: model_regs[rd] = a + b;
				cpu_pkg::SUB: model_regs[rd] = a - b;
				cpu_pkg::AND: model_regs[rd] = a & b;
				cpu_pkg::OR:  model_regs[rd] = a | b;
				cpu_pkg::XOR: model_regs[rd] = a ^ b;
				cpu_pkg::SHL: model_regs[rd] = a << b[3:0];
				cpu_pkg::SHR: model_regs[rd] = a >> b[3:0];
				cpu_pkg::MOV: model_regs[rd] = b;
				cpu_pkg::LD: begin
					model_regs[rd] = model_mem[b[5:0]];
					acc_store.push_back(1'b0);
					acc_addr.push_back(b);
					acc_data.push_back('0);
				end
				cpu_pkg::ST: begin
					model_mem[b[5:0]] = a;
					acc_store.push_back(1'b1);
					acc_addr.push_back(b);
					acc_data.push_back(a);
				end
				cpu_pkg::BZ: pc = (a == '0) ? b : pc;
				cpu_pkg::JMP: begin
					halted = (b == cur);
					pc     = b;
				end
				default: ;
			endcase
			steps++;
		end
		halt_addr = cur;
		if (!halted) begin
			$display("reference model never reached the final jump");
			abort_run();
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// data port with a random wait per request
	initial begin
		dmem_wait  <= 1'b0;
		dmem_rdata <= '0;
		forever begin
			@(posedge clk);
			if (rst) begin
				wait_left = int'(draw_random() & 32'd3);
				dmem_wait <= (wait_left != 0);
			end else if (dmem_req && !dmem_wait) begin
				if (acc_idx >= acc_addr.size()) begin
					$display("unexpected data access at address %h after the last store", dmem_addr);
					abort_run();
				end else begin
					check_word("access kind", 16'(acc_store[acc_idx]), 16'(dmem_we));
					check_word("access address", acc_addr[acc_idx], dmem_addr);
					if (dmem_we) begin
						check_word("store data", acc_data[acc_idx], dmem_wdata);
						dmem[dmem_addr[5:0]] = dmem_wdata;
						got_stores.push_back(dmem_wdata);
					end
					acc_idx++;
					wait_left = int'(draw_random() & 32'd3);
					dmem_wait <= (wait_left != 0);
				end
			end else if (dmem_req) begin
				wait_left--;
				dmem_wait <= (wait_left != 0);
			end
			if (acc_idx < acc_addr.size()) begin
				if (wait_left == 0) begin
					dmem_rdata <= dmem[acc_addr[acc_idx][5:0]];
				end else begin
					dmem_rdata <= ~dmem[acc_addr[acc_idx][5:0]];	// not valid while waiting
				end
			end
		end
	end

	always @(posedge clk) begin
		if (!rst && en_i && dut_i.ctrl.fetch) begin
			if (fetch_idx < fetch_trace.size()) begin
				check_word("fetch address", fetch_trace[fetch_idx], imem_addr);
			end else begin
				check_word("fetch address after halt", halt_addr, imem_addr);
			end
			fetch_idx++;
		end
	end

	initial begin
		repeat (RESET_CYCLES + TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout: program did not finish within %0d cycles", TIMEOUT_CYCLES);
		abort_run();
	end

	initial begin
		rst  <= 1'b1;
		en_i <= 1'b0;
		build_program();
		run_model();
		repeat (RESET_CYCLES) @(posedge clk);
		check_word("reset imem_addr", 16'h0000, imem_addr);
		check_word("reset dmem_req", 16'h0000, 16'(dmem_req));
		check_word("reset dmem_we", 16'h0000, 16'(dmem_we));
		rst  <= 1'b0;
		en_i <= 1'b1;
		while (acc_idx < acc_addr.size() || fetch_idx < fetch_trace.size()) begin
			@(posedge clk);
		end
		repeat (20) @(posedge clk);	// spin on the final jump
		for (int r = 0; r < 8; r++) begin
			check_word($sformatf("final store of r%0d", r), model_regs[r],
				got_stores[got_stores.size() - 8 + r]);
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

/* list.f */
verilog/cpu_pkg.sv
verilog/control.sv
verilog/pc_unit.sv
verilog/decoder.sv
verilog/regfile.sv
verilog/alu.sv
verilog/cpu_top.sv
bench/cpu_tb.sv

/* run.sh */
#!/bin/sh
# build and run the cpu testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f list.f --top-module cpu_tb -Mdir obj_dir

# the simulator exits non-zero on $fatal, the log decides the result
./obj_dir/Vcpu_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log; then
	echo "simulation reported failures"
	exit 1
fi
echo "simulation finished without failures"
exit 0

/* verilog/alu.sv */
`timescale 1ns/10ps

module alu (
	input  logic              clk,
	input  logic              rst,
	input  logic              en_i,
	input  cpu_pkg::control_t ctrl_i,
	input  cpu_pkg::decoded_t dec_i,
	input  cpu_pkg::word_t    a_i,
	input  cpu_pkg::word_t    b_i,
	input  cpu_pkg::word_t    imm_word_i,
	input  cpu_pkg::word_t    mem_rdata_i,
	input  logic              mem_wait_i,
	output cpu_pkg::word_t    result_o,
	output cpu_pkg::word_t    target_o,
	output cpu_pkg::word_t    operand_a_o,
	output cpu_pkg::word_t    operand_b_o,
	output logic              should_branch_o
);

	cpu_pkg::word_t  b_sel;
	cpu_pkg::shamt_t shamt;
	cpu_pkg::word_t  result_next;
	logic            branch_next;
	cpu_pkg::word_t  op_a;
	cpu_pkg::word_t  op_b;
	cpu_pkg::word_t  result;
	logic            should_branch;

	assign b_sel = dec_i.imm ? imm_word_i : b_i;
	assign shamt = b_sel[cpu_pkg::SHAMT_W-1:0];

	always_comb begin
		case (dec_i.op)
			cpu_pkg::ADD: result_next = a_i + b_sel;
			cpu_pkg::SUB: result_next = a_i - b_sel;
			cpu_pkg::AND: result_next = a_i & b_sel;
			cpu_pkg::OR:  result_next = a_i | b_sel;
			cpu_pkg::XOR: result_next = a_i ^ b_sel;
			cpu_pkg::SHL: result_next = a_i << shamt;
			cpu_pkg::SHR: result_next = a_i >> shamt;	// logical
			cpu_pkg::MOV: result_next = b_sel;
			default:      result_next = '0;
		endcase
	end

	assign branch_next = (dec_i.op == cpu_pkg::JMP) ||
		((dec_i.op == cpu_pkg::BZ) && (a_i == '0));

	always_ff @(posedge clk) begin
		if (en_i) begin
			if (ctrl_i.alu) begin
				op_a   <= a_i;
				op_b   <= b_sel;
				result <= result_next;
			end else if (ctrl_i.mem && !mem_wait_i && dec_i.op == cpu_pkg::LD) begin
				result <= mem_rdata_i;	// held through mem_delay
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			should_branch <= 1'b0;
		end else if (en_i) begin
			if (ctrl_i.alu) begin
				should_branch <= branch_next;
			end else if (ctrl_i.pc_delay) begin
				should_branch <= 1'b0;	// branch consumed
			end
		end
	end

	assign result_o        = result;
	assign target_o        = op_b;
	assign operand_a_o     = op_a;
	assign operand_b_o     = op_b;
	assign should_branch_o = should_branch;

endmodule

/* verilog/control.sv */
`timescale 1ns/10ps

module control (
	input  logic              clk,
	input  logic              rst,
	input  logic              en_i,
	input  logic              en_mem_i,
	input  logic              mem_wait_i,
	input  logic              should_branch_i,
	input  logic              imm_i,
	output cpu_pkg::control_t control_o,
	output cpu_pkg::pc_op_t   pc_op_o
);

	cpu_pkg::state_t state;
	cpu_pkg::state_t next_state;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= cpu_pkg::RST;
		end else if (en_i) begin	// en low freezes the sequence
			state <= next_state;
		end
	end

	always_comb begin
		control_o = '0;
		case (state)
			cpu_pkg::FETCH:    control_o.fetch    = 1'b1;
			cpu_pkg::DECODE:   control_o.decode   = 1'b1;
			cpu_pkg::REG_READ: control_o.reg_read = 1'b1;
			cpu_pkg::ALU:      control_o.alu      = 1'b1;
			cpu_pkg::MEM:      control_o.mem      = 1'b1;
			cpu_pkg::REG_WR: begin
				control_o.reg_wr = 1'b1;
				control_o.fetch  = !should_branch_i;	// overlap next fetch
			end
			cpu_pkg::PC_DELAY: control_o.pc_delay = 1'b1;
			default:           control_o = '0;
		endcase
	end

	always_comb begin
		pc_op_o = cpu_pkg::PC_NOP;
		case (state)
			cpu_pkg::RST: pc_op_o = cpu_pkg::PC_RESET;
			cpu_pkg::FETCH: pc_op_o = cpu_pkg::PC_INC;
			cpu_pkg::REG_READ: begin
				if (imm_i) begin
					pc_op_o = cpu_pkg::PC_INC;	// step over the immediate word
				end
			end
			cpu_pkg::REG_WR: begin
				if (should_branch_i) begin
					pc_op_o = cpu_pkg::PC_SET;
				end else begin
					pc_op_o = cpu_pkg::PC_INC;
				end
			end
			default: pc_op_o = cpu_pkg::PC_NOP;
		endcase
	end

	always_comb begin
		case (state)
			cpu_pkg::RST:      next_state = cpu_pkg::FETCH;
			cpu_pkg::FETCH:    next_state = cpu_pkg::DECODE;
			cpu_pkg::DECODE:   next_state = cpu_pkg::REG_READ;
			cpu_pkg::REG_READ: next_state = cpu_pkg::ALU;
			cpu_pkg::ALU: begin
				if (en_mem_i) begin
					next_state = cpu_pkg::MEM;
				end else begin
					next_state = cpu_pkg::REG_WR;
				end
			end
			cpu_pkg::MEM: begin
				if (mem_wait_i) begin
					next_state = cpu_pkg::MEM;	// hold the request
				end else begin
					next_state = cpu_pkg::MEM_DELAY;
				end
			end
			cpu_pkg::MEM_DELAY: next_state = cpu_pkg::REG_WR;
			cpu_pkg::REG_WR: begin
				// next instruction is already in the IR unless we branched
				if (should_branch_i) begin
					next_state = cpu_pkg::PC_DELAY;
				end else begin
					next_state = cpu_pkg::DECODE;
				end
			end
			cpu_pkg::PC_DELAY: next_state = cpu_pkg::FETCH;
			default:           next_state = cpu_pkg::FETCH;
		endcase
	end

endmodule

/* verilog/cpu_pkg.sv */
package cpu_pkg;

	localparam int WORD_W    = 16;
	localparam int REG_IDX_W = 3;
	localparam int NUM_REGS  = 8;
	localparam int OPCODE_W  = 4;
	localparam int STATE_W   = 4;
	localparam int PC_OP_W   = 2;
	localparam int SHAMT_W   = 4;

	localparam int OP_LSB  = 12;	// opcode field 15:12
	localparam int RD_LSB  = 9;	// rd field 11:9
	localparam int RS_LSB  = 6;	// rs field 8:6
	localparam int IMM_BIT = 5;	// immediate word follows

	typedef logic [WORD_W-1:0]    word_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;
	typedef logic [SHAMT_W-1:0]   shamt_t;

	typedef enum logic [OPCODE_W-1:0] {
		ADD = 4'h0,
		SUB = 4'h1,
		AND = 4'h2,
		OR  = 4'h3,
		XOR = 4'h4,
		SHL = 4'h5,
		SHR = 4'h6,
		MOV = 4'h7,
		LD  = 4'h8,
		ST  = 4'h9,
		BZ  = 4'ha,
		JMP = 4'hb
	} opcode_t;

	typedef enum logic [PC_OP_W-1:0] {
		PC_NOP   = 2'd0,
		PC_RESET = 2'd1,
		PC_INC   = 2'd2,
		PC_SET   = 2'd3
	} pc_op_t;

	typedef enum logic [STATE_W-1:0] {
		RST       = 4'h0,
		FETCH     = 4'h1,
		DECODE    = 4'h2,
		REG_READ  = 4'h3,
		ALU       = 4'h4,
		MEM       = 4'h5,
		REG_WR    = 4'h6,
		PC_DELAY  = 4'h7,
		MEM_DELAY = 4'h8
	} state_t;

	typedef struct packed {
		logic fetch;
		logic decode;
		logic reg_read;
		logic alu;
		logic mem;
		logic reg_wr;
		logic pc_delay;
	} control_t;

	typedef struct packed {
		opcode_t  op;
		reg_idx_t rd;
		reg_idx_t rs;
		logic     imm;
		logic     en_mem;	// LD or ST
		logic     is_store;
		logic     writes_rd;
	} decoded_t;

endpackage

/* verilog/cpu_top.sv */
`timescale 1ns/10ps

module cpu_top (
	input  logic           clk,
	input  logic           rst,
	input  logic           en_i,
	output cpu_pkg::word_t imem_addr_o,
	input  cpu_pkg::word_t imem_data_i,
	output logic           dmem_req_o,
	output logic           dmem_we_o,
	output cpu_pkg::word_t dmem_addr_o,
	output cpu_pkg::word_t dmem_wdata_o,
	input  cpu_pkg::word_t dmem_rdata_i,
	input  logic           dmem_wait_i
);

	cpu_pkg::control_t ctrl;
	cpu_pkg::pc_op_t   pc_op;
	cpu_pkg::word_t    pc;
	cpu_pkg::word_t    target;
	cpu_pkg::decoded_t dec;
	cpu_pkg::word_t    imm_word;
	cpu_pkg::word_t    rdata_a;
	cpu_pkg::word_t    rdata_b;
	cpu_pkg::word_t    result;
	cpu_pkg::word_t    operand_a;
	cpu_pkg::word_t    operand_b;
	logic              should_branch;
	logic              rf_we;

	control u_control (
		.clk             (clk),
		.rst             (rst),
		.en_i            (en_i),
		.en_mem_i        (dec.en_mem),
		.mem_wait_i      (dmem_wait_i),
		.should_branch_i (should_branch),
		.imm_i           (dec.imm),
		.control_o       (ctrl),
		.pc_op_o         (pc_op)
	);

	pc_unit u_pc_unit (
		.clk      (clk),
		.rst      (rst),
		.en_i     (en_i),
		.pc_op_i  (pc_op),
		.target_i (target),
		.pc_o     (pc)
	);

	decoder u_decoder (
		.clk        (clk),
		.rst        (rst),
		.en_i       (en_i),
		.ctrl_i     (ctrl),
		.instr_i    (imem_data_i),
		.dec_o      (dec),
		.imm_word_o (imm_word)
	);

	assign rf_we = ctrl.reg_wr && dec.writes_rd && en_i;

	regfile u_regfile (
		.clk       (clk),
		.rst       (rst),
		.we_i      (rf_we),
		.waddr_i   (dec.rd),
		.wdata_i   (result),
		.raddr_a_i (dec.rd),	// operand a is always rd
		.raddr_b_i (dec.rs),
		.rdata_a_o (rdata_a),
		.rdata_b_o (rdata_b)
	);

	alu u_alu (
		.clk             (clk),
		.rst             (rst),
		.en_i            (en_i),
		.ctrl_i          (ctrl),
		.dec_i           (dec),
		.a_i             (rdata_a),
		.b_i             (rdata_b),
		.imm_word_i      (imm_word),
		.mem_rdata_i     (dmem_rdata_i),
		.mem_wait_i      (dmem_wait_i),
		.result_o        (result),
		.target_o        (target),
		.operand_a_o     (operand_a),
		.operand_b_o     (operand_b),
		.should_branch_o (should_branch)
	);

	assign imem_addr_o = pc;

	// request level stays up for the whole mem state
	assign dmem_req_o   = ctrl.mem;
	assign dmem_we_o    = ctrl.mem && dec.is_store;
	assign dmem_addr_o  = operand_b;
	assign dmem_wdata_o = operand_a;

endmodule

/* verilog/decoder.sv */
`timescale 1ns/10ps

module decoder (
	input  logic              clk,
	input  logic              rst,
	input  logic              en_i,
	input  cpu_pkg::control_t ctrl_i,
	input  cpu_pkg::word_t    instr_i,
	output cpu_pkg::decoded_t dec_o,
	output cpu_pkg::word_t    imm_word_o
);

	cpu_pkg::word_t   ir;
	cpu_pkg::word_t   imm_word;
	cpu_pkg::opcode_t op;

	always_ff @(posedge clk) begin
		if (rst) begin
			ir <= '0;
		end else if (en_i && ctrl_i.fetch) begin
			ir <= instr_i;
		end
	end

	// pc already points past the instruction word here
	always_ff @(posedge clk) begin
		if (en_i && ctrl_i.reg_read && dec_o.imm) begin
			imm_word <= instr_i;
		end
	end

	assign op = cpu_pkg::opcode_t'(ir[cpu_pkg::OP_LSB +: cpu_pkg::OPCODE_W]);

	always_comb begin
		dec_o.op        = op;
		dec_o.rd        = ir[cpu_pkg::RD_LSB +: cpu_pkg::REG_IDX_W];
		dec_o.rs        = ir[cpu_pkg::RS_LSB +: cpu_pkg::REG_IDX_W];
		dec_o.imm       = ir[cpu_pkg::IMM_BIT];
		dec_o.en_mem    = (op == cpu_pkg::LD) || (op == cpu_pkg::ST);
		dec_o.is_store  = (op == cpu_pkg::ST);
		case (op)
			cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::AND, cpu_pkg::OR,
			cpu_pkg::XOR, cpu_pkg::SHL, cpu_pkg::SHR, cpu_pkg::MOV,
			cpu_pkg::LD:
				dec_o.writes_rd = 1'b1;
			default:
				dec_o.writes_rd = 1'b0;	// st, branches, unused codes
		endcase
	end

	assign imm_word_o = imm_word;

endmodule

/* verilog/pc_unit.sv */
`timescale 1ns/10ps

module pc_unit (
	input  logic            clk,
	input  logic            rst,
	input  logic            en_i,
	input  cpu_pkg::pc_op_t pc_op_i,
	input  cpu_pkg::word_t  target_i,
	output cpu_pkg::word_t  pc_o
);

	cpu_pkg::word_t pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (en_i) begin
			case (pc_op_i)
				cpu_pkg::PC_RESET: pc <= '0;
				cpu_pkg::PC_INC:   pc <= pc + 1'b1;	// word addressed
				cpu_pkg::PC_SET:   pc <= target_i;	// branch target from alu
				default:           pc <= pc;
			endcase
		end
	end

	assign pc_o = pc;

endmodule

/* verilog/regfile.sv */
`timescale 1ns/10ps

module regfile (
	input  logic              clk,
	input  logic              rst,
	input  logic              we_i,
	input  cpu_pkg::reg_idx_t waddr_i,
	input  cpu_pkg::word_t    wdata_i,
	input  cpu_pkg::reg_idx_t raddr_a_i,
	input  cpu_pkg::reg_idx_t raddr_b_i,
	output cpu_pkg::word_t    rdata_a_o,
	output cpu_pkg::word_t    rdata_b_o
);

	cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// no bypass, writes and reads never share a state
	assign rdata_a_o = regs[raddr_a_i];
	assign rdata_b_o = regs[raddr_b_i];

endmodule
